// ==== logic/cache_pkg.sv ====
package cache_pkg;

	// widths
	// --------------------
	localparam int BW_WORD_ADDR = 16;                    // core word address
	localparam int BW_BLOCK     = 2;                     // four words per block

	typedef logic [31:0]             word_t;             // data word
	typedef logic [BW_WORD_ADDR-1:0] word_addr_t;        // word address
	typedef logic [BW_BLOCK-1:0]     word_off_t;         // word inside a block
	typedef logic [31:0]             count_t;            // perf counter value

	// bundles
	// --------------------
	typedef struct packed {
		logic       rw;                                  // 1: write
		word_addr_t addr;
		word_t      data;                                // write data
	} core_req_t;

	typedef struct packed {
		logic       rw;                                  // 1: writeback, 0: fill
		word_addr_t addr;                                // block base address
		logic       block;                               // four word burst
	} mem_cmd_t;

	typedef struct packed {
		logic hit;                                       // single cycle pulses
		logic miss;
		logic writeback;
	} perf_flags_t;

	// comm port counter select on comm_i[1:0]
	typedef enum logic [1:0] {
		PERF_HITS       = 2'd0,
		PERF_MISSES     = 2'd1,
		PERF_WRITEBACKS = 2'd2
	} perf_sel_e;

endpackage

// ==== logic/tag_memory_2way.sv ====
`timescale 1ns/100ps

module tag_memory_2way import cache_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 16,
	localparam int N_SETS = CACHE_BLOCK_CAPACITY / 2,            // two blocks per set
	localparam int BW_SET = $clog2(N_SETS),
	localparam int BW_TAG = BW_WORD_ADDR - BW_SET - BW_BLOCK
) (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic [BW_SET-1:0] set_i,                             // set under lookup
	input  logic [BW_TAG-1:0] tag_i,                             // request tag
	output logic              hit_o,
	output logic              hit_way_o,
	output logic              victim_way_o,                      // way to replace
	output logic [BW_TAG-1:0] victim_tag_o,
	output logic              victim_dirty_o,
	input  logic              touch_i,                           // make touch_way_i MRU
	input  logic              touch_way_i,
	input  logic              install_i,                         // new tag into victim way
	input  logic              dirty_set_i                        // mark touch_way_i dirty
);

	logic [BW_TAG-1:0]      tag_q [2][N_SETS];                  // tag storage, per way
	logic [N_SETS-1:0][1:0] valid_q;
	logic [N_SETS-1:0][1:0] dirty_q;
	logic [N_SETS-1:0]      lru_q;                               // least recently used way
	logic [1:0]             way_hit;

	// lookup
	// --------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid_q[set_i][w] && (tag_q[w][set_i] == tag_i);
		end
	end

	assign hit_o     = |way_hit;
	assign hit_way_o = way_hit[1];                               // way 0 otherwise

	// free way first, then the LRU one
	always_comb begin
		if (!valid_q[set_i][0])
			victim_way_o = 1'b0;
		else if (!valid_q[set_i][1])
			victim_way_o = 1'b1;
		else
			victim_way_o = lru_q[set_i];
	end

	assign victim_tag_o   = tag_q[victim_way_o][set_i];
	assign victim_dirty_o = valid_q[set_i][victim_way_o] && dirty_q[set_i][victim_way_o];

	// updates
	// --------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= '0;                                       // all lines invalid
			dirty_q <= '0;
			lru_q   <= '0;
		end else begin
			if (install_i) begin
				valid_q[set_i][victim_way_o] <= 1'b1;
				dirty_q[set_i][victim_way_o] <= 1'b0;            // clean after fill
				lru_q[set_i]                 <= ~victim_way_o;   // other way ages
			end
			if (touch_i)
				lru_q[set_i] <= ~touch_way_i;
			if (dirty_set_i)
				dirty_q[set_i][touch_way_i] <= 1'b1;             // write hit
		end
	end

	always_ff @(posedge clock_i) begin
		if (install_i)
			tag_q[victim_way_o][set_i] <= tag_i;
	end

	// controller must never touch one way while installing into the other
	a_install_touch_same_way: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(install_i && touch_i) |-> (touch_way_i == victim_way_o));

endmodule

// ==== logic/cache_data_ram.sv ====
`timescale 1ns/100ps

module cache_data_ram import cache_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 16,
	localparam int BW_ADDR = $clog2(CACHE_BLOCK_CAPACITY) + BW_BLOCK,  // {way, set, word}
	localparam int DEPTH   = CACHE_BLOCK_CAPACITY << BW_BLOCK
) (
	input  logic               clock_i,
	input  logic [BW_ADDR-1:0] addr_i,
	input  logic               wren_i,
	input  word_t              data_i,
	output word_t              data_o                             // one cycle after addr_i
);

	word_t mem_q [DEPTH];                                         // both ways

	always_ff @(posedge clock_i) begin
		if (wren_i)
			mem_q[addr_i] <= data_i;
		data_o <= mem_q[addr_i];                                  // read before write
	end

endmodule

// ==== logic/cache_2way_controller.sv ====
`timescale 1ns/100ps

module cache_2way_controller import cache_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 16,
	localparam int BW_SET = $clog2(CACHE_BLOCK_CAPACITY / 2),
	localparam int BW_TAG = BW_WORD_ADDR - BW_SET - BW_BLOCK,
	localparam int BW_RAM = 1 + BW_SET + BW_BLOCK                     // {way, set, word}
) (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic              en_i,                                 // low blocks new requests

	// core side
	input  logic              core_req_valid_i,
	input  logic              core_rw_i,                            // 1: write
	input  word_t             core_data_i,
	input  logic [BW_TAG-1:0] core_tag_i,
	input  logic [BW_SET-1:0] core_set_i,
	input  word_off_t         core_word_i,
	output logic              core_done_o,
	output logic              core_hit_o,

	// tag memory
	output logic [BW_SET-1:0] set_o,
	input  logic              hit_i,
	input  logic              hit_way_i,
	input  logic              victim_way_i,
	input  logic [BW_TAG-1:0] victim_tag_i,
	input  logic              victim_dirty_i,
	output logic              touch_o,
	output logic              touch_way_o,
	output logic              install_o,
	output logic              dirty_set_o,

	// data ram
	output logic [BW_RAM-1:0] ram_addr_o,
	output logic              ram_wren_o,
	output word_t             ram_data_o,
	input  word_t             ram_data_i,

	// memory command and buffers
	output logic              mem_req_o,
	output mem_cmd_t          mem_cmd_o,
	input  logic              mem_ready_i,
	input  logic              buffer_read_ready_i,
	output logic              buffer_read_o,
	input  word_t             buffer_data_i,
	input  logic              buffer_write_ready_i,
	output logic              buffer_write_o,
	output word_t             buffer_data_o,

	output perf_flags_t       flags_o
);

	typedef enum logic [2:0] {
		IDLE, LOOKUP, HIT_READ, WB_REQ, WB_DATA, FILL_REQ, FILL_DATA, DONE
	} state_e;

	state_e    state_q, state_d;
	word_off_t cnt_q, cnt_d;                                        // burst word index
	logic      way_q, way_d;                                        // way being replaced
	logic      filled_q, filled_d;                                  // request went through a fill
	logic      wb_strobe;
	logic      fill_strobe;
	logic      last_word;

	assign last_word   = (cnt_q == '1);
	assign wb_strobe   = (state_q == WB_DATA) && buffer_write_ready_i;
	assign fill_strobe = (state_q == FILL_DATA) && buffer_read_ready_i;

	// tag memory control
	// --------------------
	assign set_o       = core_set_i;
	assign touch_o     = (state_q == LOOKUP) && hit_i;
	assign touch_way_o = hit_way_i;
	assign dirty_set_o = touch_o && core_rw_i;                      // write hit
	assign install_o   = fill_strobe && last_word;                  // last fill word

	// core, buffer and memory side
	// --------------------
	assign core_done_o    = (state_q == DONE);
	assign core_hit_o     = core_done_o && !filled_q;
	assign buffer_write_o = wb_strobe;
	assign buffer_read_o  = fill_strobe;
	assign buffer_data_o  = ram_data_i;                             // prefetched word
	assign mem_req_o      = (state_q == WB_REQ) || (state_q == FILL_REQ);

	always_comb begin
		mem_cmd_o.rw    = (state_q == WB_REQ);
		mem_cmd_o.block = 1'b1;                                     // always full block
		if (state_q == WB_REQ)
			mem_cmd_o.addr = {victim_tag_i, core_set_i, {BW_BLOCK{1'b0}}};
		else
			mem_cmd_o.addr = {core_tag_i, core_set_i, {BW_BLOCK{1'b0}}};
	end

	// ram port
	always_comb begin
		ram_addr_o = {way_q, core_set_i, cnt_q};                    // burst position
		ram_wren_o = 1'b0;
		ram_data_o = buffer_data_i;
		case (state_q)
			LOOKUP, HIT_READ: begin
				ram_addr_o = {hit_way_i, core_set_i, core_word_i};
				ram_wren_o = touch_o && core_rw_i;                  // write on hit only
				ram_data_o = core_data_i;
			end
			WB_DATA: begin
				if (wb_strobe)
					ram_addr_o = {way_q, core_set_i, cnt_q + 1'b1}; // one word ahead
			end
			FILL_DATA: begin
				ram_wren_o = fill_strobe;
			end
			default: ;
		endcase
	end

	// perf flags
	assign flags_o.hit       = touch_o && !filled_q;                // no hit after refill
	assign flags_o.miss      = (state_q == LOOKUP) && !hit_i;
	assign flags_o.writeback = flags_o.miss && victim_dirty_i;

	// FSM
	// --------------------
	always_comb begin
		state_d  = state_q;
		cnt_d    = cnt_q;
		way_d    = way_q;
		filled_d = filled_q;
		case (state_q)
			IDLE: begin
				if (en_i && core_req_valid_i) begin
					state_d  = LOOKUP;
					filled_d = 1'b0;
				end
			end
			LOOKUP: begin
				cnt_d = '0;
				if (hit_i) begin
					state_d = HIT_READ;
				end else begin
					way_d   = victim_way_i;                         // lock victim
					state_d = victim_dirty_i ? WB_REQ : FILL_REQ;
				end
			end
			HIT_READ: state_d = DONE;                               // ram data valid next
			WB_REQ: begin
				if (mem_ready_i)
					state_d = WB_DATA;
			end
			WB_DATA: begin
				if (wb_strobe) begin
					cnt_d = cnt_q + 1'b1;
					if (last_word)
						state_d = FILL_REQ;
				end
			end
			FILL_REQ: begin
				if (mem_ready_i)
					state_d = FILL_DATA;
			end
			FILL_DATA: begin
				if (fill_strobe) begin
					cnt_d = cnt_q + 1'b1;
					if (last_word) begin
						state_d  = LOOKUP;                          // replay as hit
						filled_d = 1'b1;
					end
				end
			end
			DONE: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q  <= IDLE;
			cnt_q    <= '0;
			way_q    <= 1'b0;
			filled_q <= 1'b0;
		end else begin
			state_q  <= state_d;
			cnt_q    <= cnt_d;
			way_q    <= way_d;
			filled_q <= filled_d;
		end
	end

	// request and its command stay put until memory takes them
	a_mem_req_held: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(mem_req_o && !mem_ready_i) |=> (mem_req_o && $stable(mem_cmd_o)));

	a_read_needs_ready: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		buffer_read_o |-> (buffer_read_ready_i && !mem_req_o));

endmodule

// ==== logic/cache_performance_controller.sv ====
`timescale 1ns/100ps

module cache_performance_controller import cache_pkg::*; (
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  perf_flags_t flags_i,
	input  logic [31:0] comm_i,                                     // [31] clear, [1:0] select
	output count_t      comm_o                                      // selected counter
);

	localparam int N_CNT = 3;

	count_t           cnt_q [N_CNT];                                // hits, misses, writebacks
	logic [N_CNT-1:0] inc;
	perf_sel_e        sel;
	logic             clr;

	assign inc = {flags_i.writeback, flags_i.miss, flags_i.hit};    // perf_sel_e order
	assign sel = perf_sel_e'(comm_i[1:0]);
	assign clr = comm_i[31];

	// counters
	// --------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < N_CNT; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < N_CNT; i++) begin
				if (clr && (sel == perf_sel_e'(i)))
					cnt_q[i] <= '0;                                 // clear wins
				else if (inc[i] && (cnt_q[i] != '1))
					cnt_q[i] <= cnt_q[i] + 1'b1;                    // saturate at max
			end
		end
	end

	// readback, one cycle behind comm_i
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			comm_o <= '0;
		end else begin
			case (sel)
				PERF_HITS, PERF_MISSES, PERF_WRITEBACKS:
					comm_o <= clr ? '0 : cnt_q[sel];
				default:
					comm_o <= '0;                                   // unmapped select
			endcase
		end
	end

endmodule

// ==== logic/cache_2way.sv ====
`timescale 1ns/100ps

module cache_2way import cache_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 16,                        // blocks, two per set
	localparam int BW_SET = $clog2(CACHE_BLOCK_CAPACITY / 2),
	localparam int BW_TAG = BW_WORD_ADDR - BW_SET - BW_BLOCK,
	localparam int BW_RAM = 1 + BW_SET + BW_BLOCK
) (
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  logic        en_i,
	input  logic        core_req_valid_i,
	input  core_req_t   core_req_i,                                 // held until done
	output logic        core_done_o,
	output logic        core_hit_o,
	output word_t       core_data_o,
	output logic        mem_req_o,
	output mem_cmd_t    mem_cmd_o,
	input  logic        mem_ready_i,
	input  logic        buffer_read_ready_i,
	output logic        buffer_read_o,
	input  word_t       buffer_data_i,
	input  logic        buffer_write_ready_i,
	output logic        buffer_write_o,
	output word_t       buffer_data_o,
	input  logic [31:0] comm_i,
	output count_t      comm_o
);

	// address split
	// --------------------
	logic [BW_TAG-1:0] req_tag;
	logic [BW_SET-1:0] req_set;
	word_off_t         req_word;

	assign {req_tag, req_set, req_word} = core_req_i.addr;          // [tag|set|word]

	// internal wiring
	logic [BW_SET-1:0] tm_set;
	logic              tm_hit, tm_hit_way;
	logic              tm_victim_way, tm_victim_dirty;
	logic [BW_TAG-1:0] tm_victim_tag;
	logic              tm_touch, tm_touch_way, tm_install, tm_dirty_set;
	logic [BW_RAM-1:0] ram_addr;
	logic              ram_wren;
	word_t             ram_wdata, ram_rdata;
	perf_flags_t       flags;

	assign core_data_o = ram_rdata;                                 // valid in done cycle

	tag_memory_2way #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_tag_mem (
		.clock_i        (clock_i),
		.rst_n_i        (rst_n_i),
		.set_i          (tm_set),
		.tag_i          (req_tag),
		.hit_o          (tm_hit),
		.hit_way_o      (tm_hit_way),
		.victim_way_o   (tm_victim_way),
		.victim_tag_o   (tm_victim_tag),
		.victim_dirty_o (tm_victim_dirty),
		.touch_i        (tm_touch),
		.touch_way_i    (tm_touch_way),
		.install_i      (tm_install),
		.dirty_set_i    (tm_dirty_set)
	);

	cache_data_ram #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_data_ram (
		.clock_i (clock_i),
		.addr_i  (ram_addr),
		.wren_i  (ram_wren),
		.data_i  (ram_wdata),
		.data_o  (ram_rdata)
	);

	cache_2way_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_ctrl (
		.clock_i              (clock_i),
		.rst_n_i              (rst_n_i),
		.en_i                 (en_i),
		.core_req_valid_i     (core_req_valid_i),
		.core_rw_i            (core_req_i.rw),
		.core_data_i          (core_req_i.data),
		.core_tag_i           (req_tag),
		.core_set_i           (req_set),
		.core_word_i          (req_word),
		.core_done_o          (core_done_o),
		.core_hit_o           (core_hit_o),
		.set_o                (tm_set),
		.hit_i                (tm_hit),
		.hit_way_i            (tm_hit_way),
		.victim_way_i         (tm_victim_way),
		.victim_tag_i         (tm_victim_tag),
		.victim_dirty_i       (tm_victim_dirty),
		.touch_o              (tm_touch),
		.touch_way_o          (tm_touch_way),
		.install_o            (tm_install),
		.dirty_set_o          (tm_dirty_set),
		.ram_addr_o           (ram_addr),
		.ram_wren_o           (ram_wren),
		.ram_data_o           (ram_wdata),
		.ram_data_i           (ram_rdata),
		.mem_req_o            (mem_req_o),
		.mem_cmd_o            (mem_cmd_o),
		.mem_ready_i          (mem_ready_i),
		.buffer_read_ready_i  (buffer_read_ready_i),
		.buffer_read_o        (buffer_read_o),
		.buffer_data_i        (buffer_data_i),
		.buffer_write_ready_i (buffer_write_ready_i),
		.buffer_write_o       (buffer_write_o),
		.buffer_data_o        (buffer_data_o),
		.flags_o              (flags)
	);

	cache_performance_controller i_perf (
		.clock_i (clock_i),
		.rst_n_i (rst_n_i),
		.flags_i (flags),
		.comm_i  (comm_i),
		.comm_o  (comm_o)
	);

endmodule

// ==== testbench/cache_checker.sv ====
`timescale 1ns/100ps

module cache_checker import cache_pkg::*; (
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  logic        en_i,
	input  logic        core_req_valid_i,
	input  logic        core_done_i,
	input  logic        core_hit_i,
	input  word_t       core_data_i,
	input  logic        mem_req_i,
	input  mem_cmd_t    mem_cmd_i,
	input  logic        mem_ready_i,
	input  logic        buffer_read_i,
	input  logic        buffer_write_i,
	input  word_t       buffer_data_i,                        // writeback words from the DUT
	input  count_t      comm_i
);

	word_t      ref_mem [1 << BW_WORD_ADDR];                  // what the core should see
	string      cur_name;
	int         kind;                                         // 0 none, 1 access, 2 comm
	bit         exp_hit, exp_wb, is_read, started;
	word_t      exp_data;
	int         cyc, start_cyc, comm_wait, wb_seen, fill_seen, test_errs;
	int         n_pass, n_fail;
	word_addr_t wb_base;                                      // expected victim block
	word_addr_t fill_base;                                    // block of the request
	int         wb_idx;

	task automatic start_access(string name, bit rd, bit hit, word_t data, bit wb,
			word_addr_t addr, word_addr_t wb_addr);
		cur_name  = name;
		kind      = 1;
		is_read   = rd;
		exp_hit   = hit;
		exp_data  = data;
		exp_wb    = wb;
		wb_base   = wb_addr;
		fill_base = {addr[BW_WORD_ADDR-1:BW_BLOCK], {BW_BLOCK{1'b0}}};
		started   = 0;
		wb_seen   = 0;
		fill_seen = 0;
		wb_idx    = 0;
		test_errs = 0;
	endtask

	task automatic start_comm(string name, count_t exp);
		cur_name  = name;
		kind      = 2;
		exp_data  = exp;
		comm_wait = 0;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			n_pass++;
			$display("test %s ok", cur_name);
		end else begin
			n_fail++;
			$display("test %s FAIL", cur_name);
		end
		kind = 0;
	endtask

	// control outputs at rest, called while they are stable
	task automatic check_idle(string name);
		cur_name  = name;
		test_errs = 0;
		if (core_done_i || mem_req_i || buffer_read_i || buffer_write_i) begin
			$display("%s: a control output is high after reset", name);
			test_errs++;
		end
		finish_test();
	endtask

	initial begin
		kind   = 0;
		cyc    = 0;
		n_pass = 0;
		n_fail = 0;
		wb_idx = 0;
	end

	// --------------------
	always @(posedge clock_i) begin
		cyc++;
		if (mem_req_i && mem_ready_i) begin                       // command accepted
			if (mem_cmd_i.block !== 1'b1) begin
				$display("Error %s burst: expected 1, actual %0d", cur_name,
					mem_cmd_i.block);
				test_errs++;
			end
			if (mem_cmd_i.rw) begin                               // writeback
				wb_idx = 0;
				wb_seen++;
				if (mem_cmd_i.addr !== wb_base) begin
					$display("Error %s wb address: expected %h, actual %h", cur_name,
						wb_base, mem_cmd_i.addr);
					test_errs++;
				end
			end else begin
				fill_seen++;
				if (mem_cmd_i.addr !== fill_base) begin
					$display("Error %s fill address: expected %h, actual %h", cur_name,
						fill_base, mem_cmd_i.addr);
					test_errs++;
				end
			end
		end
		if (buffer_write_i) begin
			if (buffer_data_i !== ref_mem[word_addr_t'(wb_base + wb_idx)]) begin
				$display("Error %s wb word %0d: expected %h, actual %h", cur_name, wb_idx,
					ref_mem[word_addr_t'(wb_base + wb_idx)], buffer_data_i);
				test_errs++;
			end
			wb_idx++;
		end
		if (kind == 1) begin
			if (!started && rst_n_i && en_i && core_req_valid_i) begin
				started   = 1;                                // edge that takes the request
				start_cyc = cyc;
			end else if (started && core_done_i) begin
				if (core_hit_i !== exp_hit) begin
					$display("Error %s hit: expected %0d, actual %0d", cur_name, exp_hit,
						core_hit_i);
					test_errs++;
				end
				if (exp_hit && (cyc - start_cyc - 1 != 2)) begin
					$display("Error %s latency: expected 2, actual %0d", cur_name,
						cyc - start_cyc - 1);
					test_errs++;
				end
				if (is_read && core_data_i !== exp_data) begin
					$display("Error %s: expected %h, actual %h", cur_name, exp_data,
						core_data_i);
					test_errs++;
				end
				if (wb_seen != exp_wb) begin
					$display("Error %s writebacks: expected %0d, actual %0d", cur_name,
						exp_wb, wb_seen);
					test_errs++;
				end
				if (exp_wb && wb_idx != 4) begin                  // full block out
					$display("Error %s wb words: expected 4, actual %0d", cur_name,
						wb_idx);
					test_errs++;
				end
				if (fill_seen != (exp_hit ? 0 : 1)) begin
					$display("Error %s fills: expected %0d, actual %0d", cur_name,
						exp_hit ? 0 : 1, fill_seen);
					test_errs++;
				end
				finish_test();
			end
		end else if (kind == 2) begin
			comm_wait++;
			if (comm_wait == 2) begin                             // counter readback lands
				if (comm_i !== exp_data) begin
					$display("Error %s: expected %h, actual %h", cur_name, exp_data, comm_i);
					test_errs++;
				end
				finish_test();
			end
		end
	end

endmodule

// ==== testbench/tb_cache_2way.sv ====
`timescale 1ns/100ps

module tb_cache_2way import cache_pkg::*;;

	localparam int OP_RD  = 0;
	localparam int OP_WR  = 1;
	localparam int OP_CNT = 2;                                // data[31] clears, addr[1:0] selects

	typedef struct packed {
		logic [1:0] op;
		word_addr_t addr;
		word_t      data;
		logic       exp_hit;
		logic       exp_wb;
		word_addr_t wb_addr;                                  // victim block base on writeback
	} entry_t;

	logic       clock, rst_n, en, core_req_valid;
	core_req_t  core_req;
	logic       core_done, core_hit, mem_req, mem_ready;
	word_t      core_data;
	mem_cmd_t   mem_cmd;
	logic       rd_ready, buffer_read, wr_ready, buffer_write;
	word_t      buffer_data_in, buffer_data_out;
	logic [31:0] comm;
	count_t     comm_out;

	entry_t     tbl [$];
	string      names [$];
	word_t      model [1 << BW_WORD_ADDR];                    // backing memory
	word_addr_t burst_base, nbase;
	int         burst_idx, nidx;
	int         tally [3];                                    // hits, misses, writebacks
	int         seed;

	cache_2way #(.CACHE_BLOCK_CAPACITY(16)) i_dut (
		.clock_i (clock), .rst_n_i (rst_n), .en_i (en),
		.core_req_valid_i (core_req_valid), .core_req_i (core_req),
		.core_done_o (core_done), .core_hit_o (core_hit), .core_data_o (core_data),
		.mem_req_o (mem_req), .mem_cmd_o (mem_cmd), .mem_ready_i (mem_ready),
		.buffer_read_ready_i (rd_ready), .buffer_read_o (buffer_read),
		.buffer_data_i (buffer_data_in), .buffer_write_ready_i (wr_ready),
		.buffer_write_o (buffer_write), .buffer_data_o (buffer_data_out),
		.comm_i (comm), .comm_o (comm_out)
	);

	cache_checker i_checker (
		.clock_i (clock), .rst_n_i (rst_n), .en_i (en),
		.core_req_valid_i (core_req_valid), .core_done_i (core_done),
		.core_hit_i (core_hit), .core_data_i (core_data),
		.mem_req_i (mem_req), .mem_cmd_i (mem_cmd), .mem_ready_i (mem_ready),
		.buffer_read_i (buffer_read), .buffer_write_i (buffer_write),
		.buffer_data_i (buffer_data_out), .comm_i (comm_out)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic add_entry(string name, int op, word_addr_t addr, word_t data,
			bit hit, bit wb, word_addr_t wb_addr);
		entry_t e;
		e.op      = op[1:0];
		e.addr    = addr;
		e.data    = data;
		e.exp_hit = hit;
		e.exp_wb  = wb;
		e.wb_addr = wb_addr;
		tbl.push_back(e);
		names.push_back(name);
	endtask

	// set = addr[4:2], tag = addr[15:5]; A, B, C, D share set 0
	task automatic build_table();
		add_entry("rd_first_miss",     OP_RD,  16'h0041, 0,            0, 0, 16'h0000);
		add_entry("rd_same_block_hit", OP_RD,  16'h0043, 0,            1, 0, 16'h0000);
		add_entry("wr_hit",            OP_WR,  16'h0042, 32'hA5A50001, 1, 0, 16'h0000);
		add_entry("rd_after_wr",       OP_RD,  16'h0042, 0,            1, 0, 16'h0000);
		add_entry("fill_b",            OP_RD,  16'h0081, 0,            0, 0, 16'h0000);
		add_entry("touch_a",           OP_RD,  16'h0040, 0,            1, 0, 16'h0000);
		add_entry("evict_b_with_c",    OP_RD,  16'h00C0, 0,            0, 0, 16'h0000);
		add_entry("reread_a_hit",      OP_RD,  16'h0041, 0,            1, 0, 16'h0000);
		add_entry("reread_b_miss",     OP_RD,  16'h0082, 0,            0, 0, 16'h0000);
		add_entry("evict_dirty_a",     OP_RD,  16'h0100, 0,            0, 1, 16'h0040);
		add_entry("wr_hit_d",          OP_WR,  16'h0103, 32'h0BADF00D, 1, 0, 16'h0000);
		add_entry("wr_miss",           OP_WR,  16'h0025, 32'h12345678, 0, 0, 16'h0000);
		add_entry("rd_wr_miss",        OP_RD,  16'h0025, 0,            1, 0, 16'h0000);
		add_entry("rd_a_from_memory",  OP_RD,  16'h0042, 0,            0, 0, 16'h0000);
		add_entry("cnt_hits",          OP_CNT, 16'h0000, 0,            0, 0, 16'h0000);
		add_entry("cnt_misses",        OP_CNT, 16'h0001, 0,            0, 0, 16'h0000);
		add_entry("cnt_writebacks",    OP_CNT, 16'h0002, 0,            0, 0, 16'h0000);
		add_entry("cnt_clear_hits",    OP_CNT, 16'h0000, 32'h80000000, 0, 0, 16'h0000);
		add_entry("cnt_hits_cleared",  OP_CNT, 16'h0000, 0,            0, 0, 16'h0000);
	endtask

	// memory model, random readiness for back-pressure
	// --------------------
	always @(posedge clock) begin
		mem_ready <= ($urandom % 4) != 0;
		rd_ready  <= ($urandom % 4) != 0;
		wr_ready  <= ($urandom % 4) != 0;
		nbase = burst_base;
		nidx  = burst_idx;
		if (mem_req && mem_ready) begin                       // new burst
			nbase = mem_cmd.addr;
			nidx  = 0;
		end else if (buffer_read || buffer_write) begin
			if (buffer_write)
				model[word_addr_t'(burst_base + burst_idx)] <= buffer_data_out;
			nidx = burst_idx + 1;
		end
		burst_base     <= nbase;
		burst_idx      <= nidx;
		buffer_data_in <= model[word_addr_t'(nbase + nidx)];  // next fill word
	end

	// watchdog
	initial begin
		#1;
		#(tbl.size() * 40 * 100);
		$display("watchdog: a request never completed");
		$display("tests failed");
		$finish;
	end

	// --------------------
	initial begin
		entry_t e;
		word_t  exp;
		int     sel;
		seed = $urandom(32);
		rst_n = 1'b0;
		en = 1'b0;
		core_req_valid = 1'b0;
		core_req = '0;
		mem_ready = 1'b0;
		rd_ready = 1'b0;
		wr_ready = 1'b0;
		buffer_data_in = '0;
		comm = '0;
		burst_base = '0;
		burst_idx = 0;
		tally = '{0, 0, 0};
		build_table();
		for (int i = 0; i < (1 << BW_WORD_ADDR); i++) begin
			model[i] = $urandom;
			i_checker.ref_mem[i] = model[i];                  // same contents to start
		end
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		en    <= 1'b1;
		@(negedge clock);
		i_checker.check_idle("reset_idle");
		for (int t = 0; t < tbl.size(); t++) begin
			e = tbl[t];
			@(posedge clock);
			if (e.op == OP_CNT) begin
				sel  = e.addr[1:0];
				comm <= {e.data[31], 29'b0, e.addr[1:0]};
				exp  = e.data[31] ? 0 : tally[sel];
				if (e.data[31])
					tally[sel] = 0;
				@(negedge clock);
				i_checker.start_comm(names[t], exp);
				@(posedge clock);
				@(posedge clock);
				comm <= '0;
				@(negedge clock);
			end else begin
				core_req_valid <= 1'b1;
				core_req.rw    <= (e.op == OP_WR);
				core_req.addr  <= e.addr;
				core_req.data  <= e.data;
				tally[0] += e.exp_hit;
				tally[1] += !e.exp_hit;
				tally[2] += e.exp_wb;
				@(negedge clock);
				i_checker.start_access(names[t], e.op == OP_RD, e.exp_hit,
					i_checker.ref_mem[e.addr], e.exp_wb, e.addr, e.wb_addr);
				@(posedge clock);
				while (!core_done)
					@(posedge clock);
				core_req_valid <= 1'b0;
				@(negedge clock);
				if (e.op == OP_WR)
					i_checker.ref_mem[e.addr] = e.data;
			end
		end
		repeat (2) @(posedge clock);
		$display("%0d passed, %0d failed", i_checker.n_pass, i_checker.n_fail);
		if (i_checker.n_fail == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
logic/cache_pkg.sv
logic/tag_memory_2way.sv
logic/cache_data_ram.sv
logic/cache_2way_controller.sv
logic/cache_performance_controller.sv
logic/cache_2way.sv
testbench/cache_checker.sv
testbench/tb_cache_2way.sv

// ==== Bender.yml ====
package:
  name: cache_2way

sources:
  - logic/cache_pkg.sv
  - logic/tag_memory_2way.sv
  - logic/cache_data_ram.sv
  - logic/cache_2way_controller.sv
  - logic/cache_performance_controller.sv
  - logic/cache_2way.sv
  - target: test
    files:
      - testbench/cache_checker.sv
      - testbench/tb_cache_2way.sv
